// ==== hw/swap_pkg.sv ====
// Block-swap memory domain package with address map, sizes and address views
`default_nettype none

package swap_pkg;

  // ----------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // ----------------------------------------------------------
  // Address map
  // ----------------------------------------------------------
  // Tag in the top address byte that selects the SRAM window
  localparam int unsigned RegionWidth = 8;
  localparam logic [RegionWidth-1:0] SramRegion = 8'h10;

  // Logical block number, replaced by the physical slot
  localparam int unsigned BlockIdxWidth = 16;

  // Byte offset inside one block of 256 bytes
  localparam int unsigned OffsetWidth = 8;

  // Word index inside a block, drops the two byte-lane bits
  localparam int unsigned WordIdxWidth  = OffsetWidth - 2;
  localparam int unsigned WordsPerBlock = 2 ** WordIdxWidth;

  // ----------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------
  // Default number of physical SRAM slots
  localparam int unsigned NumSlots = 4;

  // Read data returned for accesses outside the SRAM window
  localparam logic [DataWidth-1:0] ErrRdata = 32'hBADCAB1E;

  // ----------------------------------------------------------
  // Address word views
  // ----------------------------------------------------------
  // Swap view, region tag on top and offset at the bottom
  typedef struct packed {
    logic [RegionWidth-1:0]   region;
    logic [BlockIdxWidth-1:0] block;
    logic [OffsetWidth-1:0]   offset;
  } swap_view_t;

  // Same word seen either whole or split for the block lookup
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    swap_view_t           swap;
  } swap_addr_t;

endpackage

`default_nettype wire

// ==== hw/mem_req_if.sv ====
// Request interface carrying one registered memory request between pipeline stages
`default_nettype none

interface mem_req_if;
  import swap_pkg::*;

  // Qualifier, high for one cycle per item
  logic                 valid;

  // Request payload
  logic                 we;
  swap_addr_t           addr;
  logic [DataWidth-1:0] wdata;
  logic [BeWidth-1:0]   be;

  // Upstream stage drives
  modport src (
    output valid, we, addr, wdata, be
  );

  // Downstream stage samples
  modport dst (
    input  valid, we, addr, wdata, be
  );

endinterface

`default_nettype wire

// ==== hw/req_blocker.sv ====
// Request blocker that stalls the grant during block swaps and translates the block field
`default_nettype none

module req_blocker #(
  parameter int unsigned NumSlots = swap_pkg::NumSlots
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,

  // Bus manager side
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [swap_pkg::AddrWidth-1:0]       addr_i,
  input  logic [swap_pkg::DataWidth-1:0]       wdata_i,
  input  logic [swap_pkg::BeWidth-1:0]         be_i,
  output logic                                 gnt_o,

  // Swap controller side
  output logic [swap_pkg::BlockIdxWidth-1:0]   swap_addr_o,
  output logic                                 swap_valid_o,
  input  logic [$clog2(NumSlots)-1:0]          swap_idx_i,
  input  logic                                 block_i,

  // Translated request towards the decoder
  mem_req_if.src                               out_o
);
  import swap_pkg::*;

  // ----------------------------------------------------------
  // Block lookup
  // ----------------------------------------------------------
  swap_addr_t addr_in;
  swap_addr_t addr_xlat;
  logic       accept;

  assign addr_in.raw = addr_i;

  // Controller sees every pending request, also while stalled
  assign swap_valid_o = req_i;
  assign swap_addr_o  = addr_in.swap.block;

  // Grant withheld while a swap is in progress
  assign gnt_o  = req_i & ~block_i;
  assign accept = req_i & gnt_o;

  // Logical block replaced by the physical slot
  always_comb begin
    addr_xlat            = addr_in;
    addr_xlat.swap.block = BlockIdxWidth'(swap_idx_i);
  end

  // ----------------------------------------------------------
  // Output register
  // ----------------------------------------------------------
  logic                 valid_q;
  logic                 we_q;
  swap_addr_t           addr_q;
  logic [DataWidth-1:0] wdata_q;
  logic [BeWidth-1:0]   be_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= accept;
    end
  end

  // Payload only loaded on an accepted request
  always_ff @(posedge clk_i) begin
    if (accept) begin
      we_q    <= we_i;
      addr_q  <= addr_xlat;
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
  end

  assign out_o.valid = valid_q;
  assign out_o.we    = we_q;
  assign out_o.addr  = addr_q;
  assign out_o.wdata = wdata_q;
  assign out_o.be    = be_q;

endmodule

`default_nettype wire

// ==== hw/addr_decoder.sv ====
// Address decoder stage that marks each request as SRAM hit or error miss
`default_nettype none

module addr_decoder (
  input  logic      clk_i,
  input  logic      reset_i,

  // Translated request from the blocker
  mem_req_if.dst    in_i,

  // Request and routing flag towards the SRAM stage
  mem_req_if.src    out_o,
  output logic      hit_o
);
  import swap_pkg::*;

  // ----------------------------------------------------------
  // Window check
  // ----------------------------------------------------------
  logic [RegionWidth-1:0] region_tag;
  logic                   window_hit;

  // Top byte of the raw address word
  assign region_tag = in_i.addr.raw[AddrWidth-1 -: RegionWidth];
  assign window_hit = (region_tag == SramRegion);

  // ----------------------------------------------------------
  // Stage register
  // ----------------------------------------------------------
  logic                 valid_q;
  logic                 hit_q;
  logic                 we_q;
  swap_addr_t           addr_q;
  logic [DataWidth-1:0] wdata_q;
  logic [BeWidth-1:0]   be_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_i.valid;
    end
  end

  // Hit travels with the item it belongs to
  always_ff @(posedge clk_i) begin
    if (in_i.valid) begin
      hit_q   <= window_hit;
      we_q    <= in_i.we;
      addr_q  <= in_i.addr;
      wdata_q <= in_i.wdata;
      be_q    <= in_i.be;
    end
  end

  assign out_o.valid = valid_q;
  assign out_o.we    = we_q;
  assign out_o.addr  = addr_q;
  assign out_o.wdata = wdata_q;
  assign out_o.be    = be_q;
  assign hit_o       = hit_q;

endmodule

`default_nettype wire

// ==== hw/sram_rsp_stage.sv ====
// SRAM bank and bus-error responder stage that registers the bus response
`default_nettype none

module sram_rsp_stage #(
  parameter int unsigned NumSlots = swap_pkg::NumSlots
) (
  input  logic                           clk_i,
  input  logic                           reset_i,

  // Decoded request
  mem_req_if.dst                         in_i,
  input  logic                           hit_i,

  // Bus response
  output logic                           rvalid_o,
  output logic [swap_pkg::DataWidth-1:0] rdata_o,
  output logic                           err_o
);
  import swap_pkg::*;

  localparam int unsigned SlotIdxWidth = $clog2(NumSlots);
  localparam int unsigned MemIdxWidth  = SlotIdxWidth + WordIdxWidth;
  localparam int unsigned Depth        = NumSlots * WordsPerBlock;

  // ----------------------------------------------------------
  // SRAM array
  // ----------------------------------------------------------
  logic [DataWidth-1:0]   mem_q [Depth];
  logic [MemIdxWidth-1:0] word_idx;
  logic                   wr_en;

  // Slot bits of the block field on top of the word bits
  assign word_idx = {in_i.addr.swap.block[SlotIdxWidth-1:0],
                     in_i.addr.swap.offset[OffsetWidth-1:2]};

  // Misses never touch the array
  assign wr_en = in_i.valid & in_i.we & hit_i;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < BeWidth; b++) begin
        if (in_i.be[b]) begin
          mem_q[word_idx][8*b +: 8] <= in_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Response register
  // ----------------------------------------------------------
  logic                 rvalid_q;
  logic                 err_q;
  logic [DataWidth-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= in_i.valid;
      err_q    <= in_i.valid & ~hit_i;
    end
  end

  // Error pattern on a miss, zero data for a write
  always_ff @(posedge clk_i) begin
    if (in_i.valid) begin
      if (!hit_i) begin
        rdata_q <= ErrRdata;
      end else if (in_i.we) begin
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign err_o    = err_q;

endmodule

`default_nettype wire

// ==== hw/mem_domain.sv ====
// Memory domain top level chaining block-swap blocker, decoder and SRAM stage
`default_nettype none

module mem_domain #(
  parameter int unsigned NumSlots = swap_pkg::NumSlots
) (
  input  logic                               clk_i,
  input  logic                               reset_i,

  // Bus manager port
  input  logic                               req_i,
  input  logic                               we_i,
  input  logic [swap_pkg::AddrWidth-1:0]     addr_i,
  input  logic [swap_pkg::DataWidth-1:0]     wdata_i,
  input  logic [swap_pkg::BeWidth-1:0]       be_i,
  output logic                               gnt_o,
  output logic                               rvalid_o,
  output logic [swap_pkg::DataWidth-1:0]     rdata_o,
  output logic                               err_o,

  // Block swap controller port
  output logic [swap_pkg::BlockIdxWidth-1:0] swap_addr_o,
  output logic                               swap_valid_o,
  input  logic [$clog2(NumSlots)-1:0]        swap_idx_i,
  input  logic                               block_i
);

  // ----------------------------------------------------------
  // Stage links
  // ----------------------------------------------------------
  mem_req_if blk_to_dec ();
  mem_req_if dec_to_mem ();

  logic dec_hit;

  // Stage 1, swap lookup and grant
  req_blocker #(
    .NumSlots ( NumSlots )
  ) i_req_blocker (
    .clk_i,
    .reset_i,
    .req_i,
    .we_i,
    .addr_i,
    .wdata_i,
    .be_i,
    .gnt_o,
    .swap_addr_o,
    .swap_valid_o,
    .swap_idx_i,
    .block_i,
    .out_o        ( blk_to_dec )
  );

  // Stage 2, SRAM window check
  addr_decoder i_addr_decoder (
    .clk_i,
    .reset_i,
    .in_i         ( blk_to_dec ),
    .out_o        ( dec_to_mem ),
    .hit_o        ( dec_hit    )
  );

  // Stage 3, SRAM access or error response
  sram_rsp_stage #(
    .NumSlots ( NumSlots )
  ) i_sram_rsp_stage (
    .clk_i,
    .reset_i,
    .in_i         ( dec_to_mem ),
    .hit_i        ( dec_hit    ),
    .rvalid_o,
    .rdata_o,
    .err_o
  );

endmodule

`default_nettype wire

// ==== test/mem_domain_assert.sv ====
// Protocol assertions for the memory domain bus and swap controller interface
`default_nettype none

module mem_domain_assert (
  input logic clk_i,
  input logic reset_i,
  input logic req_i,
  input logic gnt_o,
  input logic block_i,
  input logic rvalid_o,
  input logic swap_valid_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Grant withheld for the whole swap
  a_no_gnt_while_blocked: assert property (@(posedge clk_i) disable iff (reset_i)
    !(gnt_o && block_i))
    else $error("gnt_o high while block_i is high");

  // Three-stage pipeline latency
  a_rsp_after_accept: assert property (@(posedge clk_i) disable iff (reset_i)
    (req_i && gnt_o) |-> ##3 rvalid_o)
    else $error("No rvalid_o three edges after an accepted request");

  a_no_stray_rsp: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_o |-> $past(req_i && gnt_o, 3))
    else $error("rvalid_o without an accepted request three edges before");

  a_swap_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    swap_valid_o == req_i)
    else $error("swap_valid_o differs from req_i");

  a_rvalid_reset: assert property (@(posedge clk_i) reset_i |=> !rvalid_o)
    else $error("rvalid_o high during reset");

endmodule

bind mem_domain mem_domain_assert i_mem_domain_assert (
  .clk_i        ( clk_i        ),
  .reset_i      ( reset_i      ),
  .req_i        ( req_i        ),
  .gnt_o        ( gnt_o        ),
  .block_i      ( block_i      ),
  .rvalid_o     ( rvalid_o     ),
  .swap_valid_o ( swap_valid_o )
);

`default_nettype wire

// ==== test/tb_mem_domain.sv ====
// Testbench for the block-swap memory domain with swap controller model and reference model
`default_nettype none

module tb_mem_domain;
  timeunit 1ns;
  timeprecision 100ps;

  import swap_pkg::*;

  localparam int unsigned SlotWidth   = $clog2(NumSlots);
  localparam int unsigned NumWords    = NumSlots * WordsPerBlock;
  // Directed word, byte-enable, stall, window tests, then the random run
  localparam int unsigned NumRequests = 10 + 7 + 1 + (2 * NumWords + 4) + 400;
  localparam int unsigned CycleLimit  = 20 * NumRequests + 200;

  logic                     clk_i = 1'b0;
  logic                     reset_i;
  logic                     req_i;
  logic                     we_i;
  logic [AddrWidth-1:0]     addr_i;
  logic [DataWidth-1:0]     wdata_i;
  logic [BeWidth-1:0]       be_i;
  logic                     gnt_o;
  logic                     rvalid_o;
  logic [DataWidth-1:0]     rdata_o;
  logic                     err_o;
  logic [BlockIdxWidth-1:0] swap_addr_o;
  logic                     swap_valid_o;
  logic [SlotWidth-1:0]     swap_idx_i;
  logic                     block_i;

  integer                   seed = 94;
  logic                     rand_block;
  string                    test_name;
  logic [DataWidth-1:0]     shadow_mem [NumWords];
  logic [DataWidth:0]       exp_q [$];
  int unsigned              accept_count;
  int unsigned              resp_count;
  int unsigned              cycle_count;

  mem_domain #(
    .NumSlots ( NumSlots )
  ) dut (
    .clk_i, .reset_i, .req_i, .we_i, .addr_i, .wdata_i, .be_i, .gnt_o,
    .rvalid_o, .rdata_o, .err_o, .swap_addr_o, .swap_valid_o, .swap_idx_i, .block_i
  );

  always #50 clk_i = ~clk_i;

  // ----------------------------------------------------------
  // Swap controller model and reference model
  // ----------------------------------------------------------
  function automatic int unsigned slot_of(input logic [BlockIdxWidth-1:0] block);
    return (int'(block) * 3 + 1) % NumSlots;
  endfunction

  assign swap_idx_i = SlotWidth'(slot_of(swap_addr_o));

  // Returns err on top of rdata, updates the shadow memory on writes
  function automatic logic [DataWidth:0] predict(input logic we, input logic [31:0] addr,
                                                 input logic [31:0] wdata, input logic [3:0] be);
    int unsigned phys;
    if (addr[31:24] != 8'h10) begin
      return {1'b1, 32'hBADCAB1E};
    end
    phys = slot_of(addr[23:8]) * 64 + addr[7:2];
    if (we) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          shadow_mem[phys][8*b +: 8] = wdata[8*b +: 8];
        end
      end
      return {1'b0, 32'h0};
    end
    return {1'b0, shadow_mem[phys]};
  endfunction

  function automatic logic [31:0] sram_addr(input logic [15:0] block, input int unsigned word);
    return {8'h10, block, 6'(word), 2'b00};
  endfunction

  // Odd multiplier keeps every word distinct
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr * 32'h9E37_79B1;
  endfunction

  // ----------------------------------------------------------
  // Checking and run control
  // ----------------------------------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "%s", reason);
  endtask

  task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      abort_run("A DUT response did not match the expected value");
    end
  endtask

  always @(negedge clk_i) begin : compare_rsp
    logic [DataWidth:0] exp_rsp;
    if (!reset_i && rvalid_o === 1'b1) begin
      if (exp_q.size() == 0) begin
        abort_run("A response arrived with no accepted request outstanding");
      end else begin
        exp_rsp = exp_q.pop_front();
        resp_count++;
        check({test_name, " rdata"}, exp_rsp[DataWidth-1:0], rdata_o);
        check({test_name, " err"}, exp_rsp[DataWidth], err_o);
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > CycleLimit) begin
      abort_run("Timeout, the run went past its cycle limit");
    end
  end

  // ----------------------------------------------------------
  // Stimulus, always entered on a falling edge
  // ----------------------------------------------------------
  task automatic drive_block();
    if (rand_block) begin
      block_i = (($random(seed) & 3) == 0);
    end else begin
      block_i = 1'b0;
    end
  endtask

  task automatic do_req(input logic we, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [3:0] be);
    logic accepted;
    req_i    = 1'b1;
    we_i     = we;
    addr_i   = addr;
    wdata_i  = wdata;
    be_i     = be;
    accepted = 1'b0;
    drive_block();
    while (!accepted) begin
      @(posedge clk_i);
      accepted = req_i & gnt_o;
      if (accepted) begin
        exp_q.push_back(predict(we, addr, wdata, be));
        accept_count++;
      end
      @(negedge clk_i);
      if (!accepted) begin
        drive_block();
      end
    end
  endtask

  task automatic go_idle();
    req_i   = 1'b0;
    we_i    = 1'b0;
    be_i    = '0;
    block_i = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  initial begin
    logic [31:0] a;
    reset_i = 1'b1;
    req_i = 1'b0;
    we_i = 1'b0;
    addr_i = '0;
    wdata_i = '0;
    be_i = '0;
    block_i = 1'b0;
    rand_block = 1'b0;
    test_name = "reset";
    accept_count = 0;
    resp_count = 0;
    cycle_count = 0;
    repeat (8) @(negedge clk_i);
    reset_i = 1'b0;

    test_name = "idle_after_reset";
    repeat (5) begin
      @(negedge clk_i);
      check({test_name, " rvalid"}, 32'd0, rvalid_o);
      check({test_name, " err"}, 32'd0, err_o);
      check({test_name, " gnt"}, 32'd0, gnt_o);
    end

    // Block 4 lands in the same slot as block 0
    test_name = "word_rw";
    for (int i = 0; i < 5; i++) begin
      do_req(1'b1, sram_addr(i, (i % 4) * 16 + 5), 32'hC0DE_0000 + i, 4'hF);
    end
    for (int i = 0; i < 5; i++) begin
      do_req(1'b0, sram_addr(i, (i % 4) * 16 + 5), 32'h0, 4'hF);
    end
    go_idle();

    test_name = "byte_enable";
    a = sram_addr(16'h0009, 12);
    do_req(1'b1, a, 32'hA5A5_A5A5, 4'hF);
    do_req(1'b1, a, 32'h1122_3344, 4'b0001);
    do_req(1'b0, a, 32'h0, 4'hF);
    do_req(1'b1, a, 32'h5566_7788, 4'b0110);
    do_req(1'b0, a, 32'h0, 4'hF);
    do_req(1'b1, a, 32'h99AA_BBCC, 4'b1000);
    do_req(1'b0, a, 32'h0, 4'hF);
    go_idle();

    test_name = "swap_stall";
    a = sram_addr(16'h0007, 3);
    req_i = 1'b1;
    we_i = 1'b1;
    addr_i = a;
    wdata_i = 32'hFEED_0007;
    be_i = 4'hF;
    block_i = 1'b1;
    repeat (6) begin
      @(negedge clk_i);
      check({test_name, " gnt"}, 32'd0, gnt_o);
      check({test_name, " swap_addr"}, 32'h7, swap_addr_o);
      check({test_name, " swap_valid"}, 32'd1, swap_valid_o);
      check({test_name, " rvalid"}, 32'd0, rvalid_o);
    end
    do_req(1'b1, a, 32'hFEED_0007, 4'hF);
    go_idle();

    // Fill every physical word, poke outside the window, then read all back
    test_name = "out_of_window";
    for (int blk = 0; blk < NumSlots; blk++) begin
      for (int w = 0; w < 64; w++) begin
        do_req(1'b1, sram_addr(blk, w), fill_word(sram_addr(blk, w)), 4'hF);
      end
    end
    do_req(1'b1, 32'h2000_0104, 32'hDEAD_BEEF, 4'hF);
    do_req(1'b1, 32'h1100_0008, 32'h0BAD_F00D, 4'hF);
    do_req(1'b0, 32'h0000_0000, 32'h0, 4'hF);
    do_req(1'b0, 32'hFF12_3400, 32'h0, 4'hF);
    for (int blk = 0; blk < NumSlots; blk++) begin
      for (int w = 0; w < 64; w++) begin
        do_req(1'b0, sram_addr(blk, w), 32'h0, 4'hF);
      end
    end
    go_idle();

    test_name = "random";
    rand_block = 1'b1;
    repeat (400) begin
      a = $random(seed);
      if (($random(seed) & 3) != 0) begin
        a[31:24] = 8'h10;
      end else if (a[31:24] == 8'h10) begin
        a[31:24] = 8'hEF;
      end
      a[1:0] = 2'b00;
      do_req($random(seed), a, $random(seed), $random(seed));
    end
    rand_block = 1'b0;
    go_idle();

    if (resp_count != accept_count || accept_count != NumRequests) begin
      abort_run("The number of responses does not match the accepted requests");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== compile.f ====
hw/swap_pkg.sv
hw/mem_req_if.sv
hw/req_blocker.sv
hw/addr_decoder.sv
hw/sram_rsp_stage.sv
hw/mem_domain.sv
test/mem_domain_assert.sv
test/tb_mem_domain.sv

// ==== Bender.yml ====
package:
  name: mem_domain

sources:
  # RTL in compile order
  - files:
      - hw/swap_pkg.sv
      - hw/mem_req_if.sv
      - hw/req_blocker.sv
      - hw/addr_decoder.sv
      - hw/sram_rsp_stage.sv
      - hw/mem_domain.sv

  # Testbench and bound assertions
  - target: test
    files:
      - test/mem_domain_assert.sv
      - test/tb_mem_domain.sv
